/* Makefile */
# Verilator build and run for the board control block testbench

SIM = obj_dir/board_ctl_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f board_ctl.f --top-module board_ctl_tb -Mdir obj_dir -o board_ctl_sim

run: compile
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "simulation reported errors"; exit 1; \
	fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* board_ctl.f */
design/ctl_frame_pkg.sv
design/board_reg_pkg.sv
design/spi_frame_rx.sv
design/ctl_reg_cell.sv
design/periph_spi_router.sv
design/board_ctl_top.sv
verification/board_ctl_tb.sv

/* design/board_ctl_top.sv */
////////////////////
// Board control block top. SPI receiver, NUM_REGS control register cells
// and the peripheral router, all in the clk domain.
////////////////////

module board_ctl_top
  import ctl_frame_pkg::*, board_reg_pkg::*;
#(
  parameter int NUM_REGS = 12
)
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     sclk,
  input  logic                     cs,           // active low
  input  logic                     special,      // active low
  input  logic                     mosi,
  input  logic [NUM_PERIPH-1:0]    periph_miso,
  output logic                     miso,
  output logic [NUM_PERIPH-1:0]    periph_cs,
  output logic [NUM_REGS-1:0][3:0] ctl_regs     // to switches, relays, converters
);

  ctl_frame_u frame;
  logic       write_stb;
  logic       soft_reset_stb;
  logic [7:0] rd_addr;
  logic [3:0] rd_value;
  logic       rx_dout;

  if (NUM_REGS < 2 || NUM_REGS > MAX_REGS)
    $error("NUM_REGS out of range");

  spi_frame_rx rx_i (
    .clk            (clk),
    .reset          (reset),
    .sclk           (sclk),
    .cs             (cs),
    .special        (special),
    .mosi           (mosi),
    .rd_value       (rd_value),
    .frame          (frame),
    .write_stb      (write_stb),
    .soft_reset_stb (soft_reset_stb),
    .rd_addr        (rd_addr),
    .rd_addr_stb    (),              // consumed inside the receiver
    .rx_dout        (rx_dout)
  );

  ////////////////////
  // register bank

  for (genvar i = 0; i < NUM_REGS; i++)
  begin : g_cell
    ctl_reg_cell #(
      .INDEX      (i),
      .INIT_VALUE (REG_RESET_VALUES[i])
    ) cell_i (
      .clk            (clk),
      .reset          (reset),
      .frame          (frame),
      .write_stb      (write_stb),
      .soft_reset_stb (soft_reset_stb),
      .value          (ctl_regs[i])
    );
  end

  periph_spi_router #(
    .NUM_REGS (NUM_REGS)
  ) router_i (
    .ctl_regs    (ctl_regs),
    .rd_addr     (rd_addr),
    .cs          (cs),
    .special     (special),
    .rx_dout     (rx_dout),
    .periph_miso (periph_miso),
    .rd_value    (rd_value),
    .periph_cs   (periph_cs),
    .miso        (miso)
  );

endmodule

/* design/board_reg_pkg.sv */
////////////////////
// Register bank sizing and board reset values for the control registers.
// Import with a wildcard where register count or reset values are needed.
////////////////////

package board_reg_pkg;

  localparam int MAX_REGS   = 16;   // upper bound for NUM_REGS
  localparam int NUM_PERIPH = 4;    // routed spi peripherals, one mux bit each

  // peripheral select register, one bit per peripheral cs
  localparam int MUX_REG_INDEX = 1;

  // board reset values, one nibble per register, index 0 in the low nibble
  //   reg 1  mux        all peripherals deselected
  //   reg 10 irange     sense switches default closed
  //   others            all off
  localparam logic [MAX_REGS-1:0][3:0] REG_RESET_VALUES = {
    4'h0, 4'h0, 4'h0, 4'h0,   // 15..12
    4'h0, 4'hF, 4'h0, 4'h0,   // 11..8, irange sense at 10
    4'h0, 4'h0, 4'h0, 4'h0,   // 7..4
    4'h0, 4'h0, 4'h0, 4'h0    // 3..0
  };

endpackage

/* design/ctl_frame_pkg.sv */
////////////////////
// SPI frame layout and address map shared by the receiver, the register
// cells and the router. Import with a wildcard in the module header.
////////////////////

package ctl_frame_pkg;

  localparam int FRAME_BITS = 16;   // addr byte + payload byte

  ////////////////////
  // frame views

  // control register write, clear nibble above set nibble
  typedef struct packed {
    logic [7:0] addr;
    logic [3:0] clr;
    logic [3:0] set;
  } ctl_wr_t;

  // plain byte view, soft-reset key and readback byte
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } ctl_data_t;

  typedef union packed {
    ctl_wr_t   wr;
    ctl_data_t dat;
  } ctl_frame_u;

  ////////////////////
  // address map

  localparam logic [7:0] CTL_BASE_ADDR   = 8'd8;    // reg i lives at base + i
  localparam logic [7:0] SOFT_RESET_ADDR = 8'd5;
  localparam logic [7:0] SOFT_RESET_KEY  = 8'hA5;   // low byte must match

endpackage

/* design/ctl_reg_cell.sv */
////////////////////
// One 4-bit control register with set, clear and toggle update.
// INDEX picks its address above CTL_BASE_ADDR, INIT_VALUE its reset value.
////////////////////

module ctl_reg_cell
  import ctl_frame_pkg::*;
#(
  parameter int         INDEX      = 0,
  parameter logic [3:0] INIT_VALUE = 4'h0
)
(
  input  logic       clk,
  input  logic       reset,
  input  ctl_frame_u frame,
  input  logic       write_stb,
  input  logic       soft_reset_stb,
  output logic [3:0] value
);

  localparam logic [7:0] CELL_ADDR = 8'(CTL_BASE_ADDR + INDEX);

  logic       hit;
  logic [3:0] both;   // bits both set and cleared

  assign hit  = frame.wr.addr == CELL_ADDR;
  assign both = frame.wr.set & frame.wr.clr;

  always_ff @(posedge clk)
  begin
    if (reset || soft_reset_stb)
      value <= INIT_VALUE;
    else if (write_stb && hit)
    begin
      if (|both)
        value <= value ^ both;                           // toggle overlap only
      else
        value <= (value | frame.wr.set) & ~frame.wr.clr; // set, then clear
    end
  end

  // toggle leaves the unmasked bits alone
  toggle_masked: assert property (@(posedge clk) disable iff (reset)
    (write_stb && hit && |both) |=> ((value ^ $past(value)) == $past(both)));

endmodule

/* design/periph_spi_router.sv */
////////////////////
// Readback lookup over the register nibbles, peripheral cs routing and
// miso select. All paths combinational so routed peripherals see the pins.
////////////////////

module periph_spi_router
  import ctl_frame_pkg::*, board_reg_pkg::*;
#(
  parameter int NUM_REGS = 12
)
(
  input  logic [NUM_REGS-1:0][3:0]  ctl_regs,
  input  logic [7:0]                rd_addr,
  input  logic                      cs,        // active low
  input  logic                      special,   // active low
  input  logic                      rx_dout,
  input  logic [NUM_PERIPH-1:0]     periph_miso,
  output logic [3:0]                rd_value,
  output logic [NUM_PERIPH-1:0]     periph_cs,
  output logic                      miso
);

  localparam int IDX_W = $clog2(MAX_REGS);

  logic [NUM_PERIPH-1:0] mux_sel;
  logic [7:0]            rd_offset;
  logic [IDX_W-1:0]      rd_idx;
  logic                  rd_mapped;
  logic                  pass_on;

  assign mux_sel = ctl_regs[MUX_REG_INDEX][NUM_PERIPH-1:0];

  ////////////////////
  // readback lookup

  assign rd_offset = rd_addr - CTL_BASE_ADDR;      // wraps when below base
  assign rd_idx    = rd_offset[IDX_W-1:0];
  assign rd_mapped = (rd_addr >= CTL_BASE_ADDR) && (rd_offset < 8'(NUM_REGS));

  always_comb
  begin
    rd_value = 4'h0;                  // unmapped reads as zero
    if (rd_mapped)
      rd_value = ctl_regs[rd_idx];
  end

  ////////////////////
  // peripheral routing

  // cs only forwarded outside our own frames
  assign pass_on   = ~cs & special;
  assign periph_cs = ~({NUM_PERIPH{pass_on}} & mux_sel);

  always_comb
  begin
    if (!special)
      miso = rx_dout;                  // our own readback
    else
      miso = |(periph_miso & mux_sel); // selected peripherals, wired-or
  end

  // sampled while cs was still low, so this covers the whole frame
  no_periph_cs_in_own_frame: assert property (@(posedge cs)
    !special |-> &periph_cs);

endmodule

/* design/spi_frame_rx.sv */
////////////////////
// SPI slave front end in the clk domain. Pins are synchronized and edge
// detected, mosi is shifted in, readback shifted out, and a validated frame
// ends in a one-cycle write or soft-reset strobe.
////////////////////

module spi_frame_rx
  import ctl_frame_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       sclk,
  input  logic       cs,           // active low
  input  logic       special,      // active low
  input  logic       mosi,
  input  logic [3:0] rd_value,     // looked up from rd_addr
  output ctl_frame_u frame,
  output logic       write_stb,
  output logic       soft_reset_stb,
  output logic [7:0] rd_addr,
  output logic       rd_addr_stb,
  output logic       rx_dout
);

  localparam logic [3:0] PIN_IDLE = 4'b0110;   // sclk lo, cs hi, special hi, mosi lo
  localparam logic [4:0] CNT_FULL = 5'(FRAME_BITS);
  localparam logic [4:0] CNT_MAX  = 5'(FRAME_BITS + 1);   // over-long marker
  localparam logic [4:0] CNT_ADDR = 5'(FRAME_BITS / 2 - 1);

  logic [3:0] pin_s1;
  logic [3:0] pin_s2;
  logic       sclk_q;
  logic       cs_q;
  logic       sclk_s;
  logic       cs_s;
  logic       special_s;
  logic       mosi_s;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_rise;
  logic       selected;
  logic [4:0] bit_cnt;
  logic [7:0] rdbk_sr;
  logic       frame_ok;
  logic       key_ok;

  ////////////////////
  // pin sync

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pin_s1 <= PIN_IDLE;
      pin_s2 <= PIN_IDLE;
      sclk_q <= 1'b0;
      cs_q   <= 1'b1;
    end
    else
    begin
      pin_s1 <= {sclk, cs, special, mosi};
      pin_s2 <= pin_s1;
      sclk_q <= sclk_s;    // one more stage for edges
      cs_q   <= cs_s;
    end
  end

  assign {sclk_s, cs_s, special_s, mosi_s} = pin_s2;

  assign sclk_rise = sclk_s & ~sclk_q;
  assign sclk_fall = ~sclk_s & sclk_q;
  assign cs_rise   = cs_s & ~cs_q;        // end of frame
  assign selected  = ~cs_s & ~special_s;  // frame addressed to this block

  ////////////////////
  // shift in

  // msb first, payload reg so no reset
  always_ff @(posedge clk)
  begin
    if (sclk_rise && selected)
      frame <= ctl_frame_u'({frame[FRAME_BITS-2:0], mosi_s});
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      bit_cnt <= '0;
    else if (cs_s)
      bit_cnt <= '0;                          // idle between frames
    else if (sclk_rise && !special_s && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 5'd1;              // sticks at 17
  end

  // address byte complete, router lookup is combinational
  always_ff @(posedge clk)
  begin
    if (reset)
      rd_addr_stb <= 1'b0;
    else
      rd_addr_stb <= sclk_rise && selected && bit_cnt == CNT_ADDR;
  end

  assign rd_addr = frame.dat.data;   // address still in the low byte here

  ////////////////////
  // readback out

  always_ff @(posedge clk)
  begin
    if (reset || cs_s)
    begin
      rdbk_sr <= '0;
      rx_dout <= 1'b0;
    end
    else if (rd_addr_stb)
      rdbk_sr <= {4'b0, rd_value};
    else if (sclk_fall)
    begin
      rx_dout <= rdbk_sr[7];             // master samples on next rise
      rdbk_sr <= {rdbk_sr[6:0], 1'b0};
    end
  end

  ////////////////////
  // commit

  assign frame_ok = cs_rise && !special_s && bit_cnt == CNT_FULL;
  assign key_ok   = frame.dat.addr == SOFT_RESET_ADDR && frame.dat.data == SOFT_RESET_KEY;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      write_stb      <= 1'b0;
      soft_reset_stb <= 1'b0;
    end
    else
    begin
      write_stb      <= frame_ok && !key_ok;
      soft_reset_stb <= frame_ok && key_ok;
    end
  end

  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(write_stb && soft_reset_stb));

endmodule

/* verification/board_ctl_tb.sv */
////////////////////
// Testbench for the board control block. LFSR driven SPI frames, checked
// against a register model for writes, toggles, soft reset, readback and
// peripheral routing.
////////////////////

module board_ctl_tb
  import ctl_frame_pkg::*, board_reg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REGS   = 12;
  localparam int SETTLE_MAX = 50;   // clk cycles per wait
  localparam int HALF_SCLK  = 4;    // clk cycles per sclk half period

  logic                     clk;
  logic                     reset;
  logic                     sclk;
  logic                     cs;            // active low
  logic                     special;       // active low
  logic                     mosi;
  logic [NUM_PERIPH-1:0]    periph_miso;
  logic                     miso;
  logic [NUM_PERIPH-1:0]    periph_cs;
  logic [NUM_REGS-1:0][3:0] ctl_regs;

  logic [31:0] lfsr;
  logic [3:0]  model [NUM_REGS];    // expected register bank
  int          pass_cnt;
  int          fail_cnt;
  int          rb_pass;             // readback checks, kept apart
  int          rb_fail;
  int          test_pass0;
  int          test_fail0;

  board_ctl_top #(
    .NUM_REGS (NUM_REGS)
  ) dut_i (
    .clk         (clk),
    .reset       (reset),
    .sclk        (sclk),
    .cs          (cs),
    .special     (special),
    .mosi        (mosi),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs   (periph_cs),
    .ctl_regs    (ctl_regs)
  );

  always #20 clk = ~clk;   // 40 ns period

  ////////////////////
  // random bits

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);        // one step per bit
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  ////////////////////
  // register model

  function automatic logic [4*NUM_REGS-1:0] expected_bank();
    logic [4*NUM_REGS-1:0] w;
    w = '0;
    for (int i = 0; i < NUM_REGS; i++)
      w = {model[i], w[4*NUM_REGS-1:4]};   // reg 0 ends up lowest
    return w;
  endfunction

  // reg i answers at base + i, anything else reads zero
  function automatic logic [3:0] expected_read(input logic [7:0] addr);
    logic [3:0] v;
    v = 4'h0;
    for (int i = 0; i < NUM_REGS; i++)
      if (addr == CTL_BASE_ADDR + 8'(i))
        v = model[i];
    return v;
  endfunction

  function automatic void apply_frame(input ctl_frame_u f);
    logic [3:0] both;
    both = f.wr.set & f.wr.clr;
    if (f.dat.addr == SOFT_RESET_ADDR && f.dat.data == SOFT_RESET_KEY)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        model[i] = REG_RESET_VALUES[i];
    end
    else
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        if (f.wr.addr != CTL_BASE_ADDR + 8'(i))
          continue;
        if (both != 4'h0)
          model[i] = model[i] ^ both;                   // overlap toggles
        else
          model[i] = (model[i] | f.wr.set) & ~f.wr.clr;
      end
    end
  endfunction

  ////////////////////
  // spi driver and checks

  // msb first from bit 16, miso sampled just before each rise
  task automatic send_frame(input logic [16:0] bits, input int nbits, input logic spec,
                            output logic [7:0] rb);
    logic [16:0] sr;
    sr      = bits;
    rb      = '0;
    special = spec;
    repeat (HALF_SCLK) @(negedge clk);
    cs = 1'b0;
    repeat (HALF_SCLK) @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      sclk = 1'b0;
      mosi = sr[16];
      sr   = {sr[15:0], 1'b0};
      repeat (HALF_SCLK) @(negedge clk);
      if (i >= 8 && i < FRAME_BITS)
        rb = {rb[6:0], miso};        // readback byte
      sclk = 1'b1;
      repeat (HALF_SCLK) @(negedge clk);
    end
    sclk = 1'b0;
    repeat (HALF_SCLK) @(negedge clk);
    cs = 1'b1;
    repeat (HALF_SCLK) @(negedge clk);   // special held past the cs rise
    special = 1'b1;
  endtask

  // bank must match the model and hold for 8 cycles
  task automatic check_regs();
    int stable;
    int cycles;
    stable = 0;
    cycles = 0;
    while (stable < 8 && cycles < SETTLE_MAX)
    begin
      @(negedge clk);
      cycles++;
      if (ctl_regs === expected_bank())
        stable++;
      else
        stable = 0;
    end
    if (stable < 8)
    begin
      $display("** Error: ctl_regs = %h, expected %h", ctl_regs, expected_bank());
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic write_frame(input ctl_frame_u f, input int nbits, input logic spec,
                             input logic check_rb);
    logic [16:0] bits;
    logic [7:0]  rb;
    logic [7:0]  rb_exp;
    int          n;
    bits   = {f, 1'(rand_bits(1))};            // 17th bit only on long frames
    rb_exp = {4'h0, expected_read(f.wr.addr)}; // value before the write
    send_frame(bits, nbits, spec, rb);
    if (check_rb && !spec)
    begin
      n = (nbits < FRAME_BITS ? nbits : FRAME_BITS) - 8;   // short frame cuts it
      if (rb !== (rb_exp >> (8 - n)))
      begin
        $display("** Error: miso readback = %h, expected %h", rb, rb_exp >> (8 - n));
        rb_fail++;
      end
      else
        rb_pass++;
    end
    if (nbits == FRAME_BITS && !spec)
      apply_frame(f);
    check_regs();
  endtask

  task automatic start_test();
    test_pass0 = pass_cnt;
    test_fail0 = fail_cnt;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name,
             pass_cnt - test_pass0 + fail_cnt - test_fail0, fail_cnt - test_fail0);
  endtask

  ////////////////////
  // tests

  initial
  begin
    ctl_frame_u f;
    int         kind;
    int         nbits;
    logic [3:0] mask;
    logic [3:0] mux_v;
    logic [3:0] cs_exp;
    logic       miso_exp;
    logic [7:0] key;

    clk         = 1'b0;
    reset       = 1'b1;
    sclk        = 1'b0;
    cs          = 1'b1;
    special     = 1'b1;
    mosi        = 1'b0;
    periph_miso = '0;
    lfsr        = 32'h54fa_ff3d;
    pass_cnt    = 0;
    fail_cnt    = 0;
    rb_pass     = 0;
    rb_fail     = 0;
    for (int i = 0; i < NUM_REGS; i++)
      model[i] = REG_RESET_VALUES[i];
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // 1 reset state
    start_test();
    if (ctl_regs !== REG_RESET_VALUES[NUM_REGS-1:0])
    begin
      $display("** Error: ctl_regs = %h, expected %h", ctl_regs,
               REG_RESET_VALUES[NUM_REGS-1:0]);
      fail_cnt++;
    end
    else
      pass_cnt++;
    // peripheral frame, cleared mux register routes nothing
    cs          = 1'b0;
    periph_miso = 4'hF;
    @(negedge clk);
    if (periph_cs !== 4'hF)
    begin
      $display("** Error: periph_cs = %h, expected %h", periph_cs, 4'hF);
      fail_cnt++;
    end
    else
      pass_cnt++;
    if (miso !== 1'b0)
    begin
      $display("** Error: miso = %h, expected %h", miso, 1'b0);
      fail_cnt++;
    end
    else
      pass_cnt++;
    cs          = 1'b1;
    periph_miso = '0;
    @(negedge clk);
    special = 1'b0;                 // miso now from our readback shifter
    @(negedge clk);
    if (miso !== 1'b0)
    begin
      $display("** Error: miso = %h, expected %h", miso, 1'b0);
      fail_cnt++;
    end
    else
      pass_cnt++;
    special = 1'b1;
    @(negedge clk);
    end_test("test 1 reset values");

    // 2 random writes, bad lengths, special high, stray addresses
    start_test();
    for (int t = 0; t < 200; t++)
    begin
      kind      = int'(rand_bits(3));
      f.wr.addr = CTL_BASE_ADDR + 8'(int'(rand_bits(4)) % NUM_REGS);
      if (kind == 0)
        f.wr.addr = 8'(rand_bits(8));   // mostly off the map
      f.wr.clr = 4'(rand_bits(4));
      f.wr.set = 4'(rand_bits(4));
      nbits    = (kind == 1) ? 15 : (kind == 2) ? 17 : FRAME_BITS;
      write_frame(f, nbits, kind == 3, 1'b1);
    end
    end_test("test 2 random writes");
    $display("test 5 readback during test 2: %0d checks, %0d errors",
             rb_pass + rb_fail, rb_fail);

    // 3 overlap toggles
    start_test();
    for (int t = 0; t < 30; t++)
    begin
      mask = 4'(rand_bits(4));
      if (mask == 4'h0)
        mask = 4'h8;
      f.wr.addr = CTL_BASE_ADDR + 8'(int'(rand_bits(4)) % NUM_REGS);
      f.wr.set  = mask | 4'(rand_bits(4));
      f.wr.clr  = mask;                 // overlap is exactly mask
      write_frame(f, FRAME_BITS, 1'b0, 1'b0);
    end
    end_test("test 3 toggle writes");

    // 4 soft reset, wrong key then right key
    start_test();
    f.wr.addr = CTL_BASE_ADDR;
    f.wr.clr  = 4'h0;
    f.wr.set  = 4'hF;
    write_frame(f, FRAME_BITS, 1'b0, 1'b0);
    f.wr.addr = CTL_BASE_ADDR + 8'(NUM_REGS - 1);
    write_frame(f, FRAME_BITS, 1'b0, 1'b0);
    key = 8'(rand_bits(8));
    if (key == SOFT_RESET_KEY)
      key = ~key;
    f.dat.addr = SOFT_RESET_ADDR;
    f.dat.data = key;
    write_frame(f, FRAME_BITS, 1'b0, 1'b0);
    f.dat.data = SOFT_RESET_KEY;
    write_frame(f, FRAME_BITS, 1'b0, 1'b0);
    if (ctl_regs !== REG_RESET_VALUES[NUM_REGS-1:0])
    begin
      $display("** Error: ctl_regs = %h, expected %h", ctl_regs,
               REG_RESET_VALUES[NUM_REGS-1:0]);
      fail_cnt++;
    end
    else
      pass_cnt++;
    end_test("test 4 soft reset");

    // 6 peripheral routing
    start_test();
    for (int t = 0; t < 16; t++)
    begin
      mux_v     = 4'(rand_bits(4));
      f.wr.addr = CTL_BASE_ADDR + 8'(MUX_REG_INDEX);
      f.wr.set  = mux_v;
      f.wr.clr  = ~mux_v;               // no overlap, lands on mux_v
      write_frame(f, FRAME_BITS, 1'b0, 1'b0);
      for (int j = 0; j < 8; j++)
      begin
        cs          = 1'(rand_bits(1));
        periph_miso = 4'(rand_bits(4));
        @(negedge clk);
        cs_exp   = cs ? 4'hF : ~mux_v;   // selected lines follow cs
        miso_exp = |(periph_miso & mux_v);
        if (periph_cs !== cs_exp)
        begin
          $display("** Error: periph_cs = %h, expected %h", periph_cs, cs_exp);
          fail_cnt++;
        end
        else
          pass_cnt++;
        if (miso !== miso_exp)
        begin
          $display("** Error: miso = %h, expected %h", miso, miso_exp);
          fail_cnt++;
        end
        else
          pass_cnt++;
      end
      cs          = 1'b1;
      periph_miso = '0;
    end
    end_test("test 6 peripheral routing");

    $display("checks passed %0d, failed %0d", pass_cnt + rb_pass, fail_cnt + rb_fail);
    if (fail_cnt + rb_fail == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
